//--- Makefile
TOP = rename_tb

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf obj_dir

.PHONY: all compile run clean

//--- common/rn_if.sv
`timescale 1ns/100ps

interface rn_bundle_if import rn_pkg::*; ();
    logic       valid;
    rn_bundle_t bundle;
    logic       fire;   // Head consumed at this edge

    modport skid (
        output valid,
        output bundle,
        input  fire
    );

    modport dispatch (
        input  valid,
        input  bundle,
        output fire
    );
endinterface

interface rn_map_if import rn_pkg::*; ();
    logic [NUM_SRC-1:0][AREG_W-1:0]   src_areg;   // l0 rs1, l0 rs2, l1 rs1, l1 rs2
    logic [NUM_SRC-1:0][PREG_W-1:0]   src_preg;
    logic [NUM_LANES-1:0][AREG_W-1:0] dst_areg;
    logic [NUM_LANES-1:0][PREG_W-1:0] dst_preg;   // Current mapping of rd
    logic [NUM_LANES-1:0]             wr_en;
    logic [NUM_LANES-1:0][AREG_W-1:0] wr_areg;
    logic [NUM_LANES-1:0][PREG_W-1:0] wr_preg;

    modport dispatch (
        output src_areg,
        output dst_areg,
        output wr_en,
        output wr_areg,
        output wr_preg,
        input  src_preg,
        input  dst_preg
    );

    modport tbl (
        input  src_areg,
        input  dst_areg,
        input  wr_en,
        input  wr_areg,
        input  wr_preg,
        output src_preg,
        output dst_preg
    );
endinterface

//--- common/rn_pkg.sv
package rn_pkg;

    localparam int AREG_W    = 5;
    localparam int PREG_W    = 6;
    localparam int NUM_AREG  = 32;
    localparam int NUM_LANES = 2;
    localparam int NUM_SRC   = 2 * NUM_LANES;   // rs1 and rs2 per lane

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        SKID_EMPTY,
        SKID_ONE,
        SKID_TWO
    } skid_state_e;

    typedef struct packed {
        logic              valid;
        alu_op_e           op;
        logic [AREG_W-1:0] rs1;
        logic [AREG_W-1:0] rs2;
        logic [AREG_W-1:0] rd;
        logic              writes_rd;
    } rn_uop_t;

    typedef rn_uop_t [NUM_LANES-1:0] rn_bundle_t;   // Lane 0 valid with bundle

endpackage

//--- logic/rename.sv
`timescale 1ns/100ps

module rename import rn_pkg::*; (
    input  logic              cpu_clock_i,
    input  logic              rst_i,
    input  logic              flush_i,
    // Incoming bundle
    input  alu_op_e           lane0_op_i,
    input  logic [AREG_W-1:0] lane0_rs1_i,
    input  logic [AREG_W-1:0] lane0_rs2_i,
    input  logic [AREG_W-1:0] lane0_rd_i,
    input  logic              lane0_writes_rd_i,
    input  alu_op_e           lane1_op_i,
    input  logic [AREG_W-1:0] lane1_rs1_i,
    input  logic [AREG_W-1:0] lane1_rs2_i,
    input  logic [AREG_W-1:0] lane1_rd_i,
    input  logic              lane1_writes_rd_i,
    input  logic              lane1_valid_i,
    input  logic              valid_i,
    output logic              rn_busy_o,
    // Free list
    output logic              fl_rd0_o,
    output logic              fl_rd1_o,
    input  logic [PREG_W-1:0] fl_data0_i,
    input  logic [PREG_W-1:0] fl_data1_i,
    input  logic              fl_empty0_i,
    input  logic              fl_empty1_i,
    // Execution cluster
    output logic              ms_ins0_valid_o,
    output alu_op_e           ms_ins0_op_o,
    output logic [PREG_W-1:0] ms_ins0_rs1_o,
    output logic [PREG_W-1:0] ms_ins0_rs2_o,
    output logic [PREG_W-1:0] ms_ins0_dest_o,
    output logic              ms_ins1_valid_o,
    output alu_op_e           ms_ins1_op_o,
    output logic [PREG_W-1:0] ms_ins1_rs1_o,
    output logic [PREG_W-1:0] ms_ins1_rs2_o,
    output logic [PREG_W-1:0] ms_ins1_dest_o,
    input  logic              ms_busy_i,
    // Retire unit
    output logic              rcu_push_o,
    output logic              rcu_ins1_valid_o,
    output logic              rcu_ins0_alloc_o,
    output logic [AREG_W-1:0] rcu_ins0_arch_o,
    output logic [PREG_W-1:0] rcu_ins0_old_preg_o,
    output logic [PREG_W-1:0] rcu_ins0_new_preg_o,
    output logic              rcu_ins1_alloc_o,
    output logic [AREG_W-1:0] rcu_ins1_arch_o,
    output logic [PREG_W-1:0] rcu_ins1_old_preg_o,
    output logic [PREG_W-1:0] rcu_ins1_new_preg_o,
    input  logic              rcu_busy_i,
    // Commit
    input  logic              cm0_we_i,
    input  logic [AREG_W-1:0] cm0_arch_i,
    input  logic [PREG_W-1:0] cm0_phys_i,
    input  logic              cm1_we_i,
    input  logic [AREG_W-1:0] cm1_arch_i,
    input  logic [PREG_W-1:0] cm1_phys_i
);

    rn_bundle_t                       bundle_in;
    logic [NUM_LANES-1:0]             fl_rd;
    logic [NUM_LANES-1:0]             ms_valid;
    alu_op_e [NUM_LANES-1:0]          ms_op;
    logic [NUM_LANES-1:0][PREG_W-1:0] ms_rs1;
    logic [NUM_LANES-1:0][PREG_W-1:0] ms_rs2;
    logic [NUM_LANES-1:0][PREG_W-1:0] ms_dest;
    logic [NUM_LANES-1:0]             rcu_alloc;
    logic [NUM_LANES-1:0][AREG_W-1:0] rcu_arch;
    logic [NUM_LANES-1:0][PREG_W-1:0] rcu_old;
    logic [NUM_LANES-1:0][PREG_W-1:0] rcu_new;

    rn_bundle_if bundle_bus ();
    rn_map_if    map_bus ();

    assign bundle_in[0] = '{valid: 1'b1, op: lane0_op_i, rs1: lane0_rs1_i,
                            rs2: lane0_rs2_i, rd: lane0_rd_i,
                            writes_rd: lane0_writes_rd_i};
    assign bundle_in[1] = '{valid: lane1_valid_i, op: lane1_op_i, rs1: lane1_rs1_i,
                            rs2: lane1_rs2_i, rd: lane1_rd_i,
                            writes_rd: lane1_writes_rd_i};

    // **************************************************
    // Stage blocks
    // **************************************************
    rn_skid_buffer u_skid (
        .cpu_clock_i (cpu_clock_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .valid_i     (valid_i),
        .bundle_i    (bundle_in),
        .busy_o      (rn_busy_o),
        .out         (bundle_bus.skid)
    );

    rn_map_table u_map (
        .cpu_clock_i (cpu_clock_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .map         (map_bus.tbl),
        .cm_we_i     ({cm1_we_i, cm0_we_i}),
        .cm_arch_i   ({cm1_arch_i, cm0_arch_i}),
        .cm_phys_i   ({cm1_phys_i, cm0_phys_i})
    );

    rn_dispatch u_dispatch (
        .in                  (bundle_bus.dispatch),
        .map                 (map_bus.dispatch),
        .flush_i             (flush_i),
        .ms_busy_i           (ms_busy_i),
        .rcu_busy_i          (rcu_busy_i),
        .fl_empty_i          ({fl_empty1_i, fl_empty0_i}),
        .fl_data_i           ({fl_data1_i, fl_data0_i}),
        .fl_rd_o             (fl_rd),
        .ms_insn_valid_o     (ms_valid),
        .ms_insn_op_o        (ms_op),
        .ms_insn_rs1_o       (ms_rs1),
        .ms_insn_rs2_o       (ms_rs2),
        .ms_insn_dest_o      (ms_dest),
        .rcu_push_o          (rcu_push_o),
        .rcu_ins1_valid_o    (rcu_ins1_valid_o),
        .rcu_insn_alloc_o    (rcu_alloc),
        .rcu_insn_arch_o     (rcu_arch),
        .rcu_insn_old_preg_o (rcu_old),
        .rcu_insn_new_preg_o (rcu_new)
    );

    // Lane arrays out to flat ports
    assign fl_rd0_o = fl_rd[0];
    assign fl_rd1_o = fl_rd[1];

    assign ms_ins0_valid_o = ms_valid[0];
    assign ms_ins0_op_o    = ms_op[0];
    assign ms_ins0_rs1_o   = ms_rs1[0];
    assign ms_ins0_rs2_o   = ms_rs2[0];
    assign ms_ins0_dest_o  = ms_dest[0];
    assign ms_ins1_valid_o = ms_valid[1];
    assign ms_ins1_op_o    = ms_op[1];
    assign ms_ins1_rs1_o   = ms_rs1[1];
    assign ms_ins1_rs2_o   = ms_rs2[1];
    assign ms_ins1_dest_o  = ms_dest[1];

    assign rcu_ins0_alloc_o    = rcu_alloc[0];
    assign rcu_ins0_arch_o     = rcu_arch[0];
    assign rcu_ins0_old_preg_o = rcu_old[0];
    assign rcu_ins0_new_preg_o = rcu_new[0];
    assign rcu_ins1_alloc_o    = rcu_alloc[1];
    assign rcu_ins1_arch_o     = rcu_arch[1];
    assign rcu_ins1_old_preg_o = rcu_old[1];
    assign rcu_ins1_new_preg_o = rcu_new[1];

endmodule

//--- logic/rn_dispatch.sv
`timescale 1ns/100ps

module rn_dispatch import rn_pkg::*; (
    rn_bundle_if.dispatch                    in,
    rn_map_if.dispatch                       map,
    input  logic                             flush_i,
    input  logic                             ms_busy_i,
    input  logic                             rcu_busy_i,
    input  logic [NUM_LANES-1:0]             fl_empty_i,
    input  logic [NUM_LANES-1:0][PREG_W-1:0] fl_data_i,
    output logic [NUM_LANES-1:0]             fl_rd_o,
    output logic [NUM_LANES-1:0]             ms_insn_valid_o,
    output alu_op_e [NUM_LANES-1:0]          ms_insn_op_o,
    output logic [NUM_LANES-1:0][PREG_W-1:0] ms_insn_rs1_o,
    output logic [NUM_LANES-1:0][PREG_W-1:0] ms_insn_rs2_o,
    output logic [NUM_LANES-1:0][PREG_W-1:0] ms_insn_dest_o,
    output logic                             rcu_push_o,
    output logic                             rcu_ins1_valid_o,
    output logic [NUM_LANES-1:0]             rcu_insn_alloc_o,
    output logic [NUM_LANES-1:0][AREG_W-1:0] rcu_insn_arch_o,
    output logic [NUM_LANES-1:0][PREG_W-1:0] rcu_insn_old_preg_o,
    output logic [NUM_LANES-1:0][PREG_W-1:0] rcu_insn_new_preg_o
);

    logic                 stall;
    logic [NUM_LANES-1:0] alloc;

    assign stall   = flush_i | ms_busy_i | rcu_busy_i | (|fl_empty_i);
    assign in.fire = in.valid & ~stall;

    assign rcu_push_o       = in.fire;
    assign rcu_ins1_valid_o = in.valid & in.bundle[1].valid;

    // **************************************************
    // Per-lane rename
    // **************************************************
    always_comb begin
        rn_uop_t lane;
        for (int n = 0; n < NUM_LANES; n++) begin
            lane     = in.bundle[n];
            alloc[n] = in.fire & lane.valid & lane.writes_rd & (lane.rd != '0);

            map.src_areg[2*n]   = lane.rs1;
            map.src_areg[2*n+1] = lane.rs2;
            map.dst_areg[n]     = lane.rd;
            map.wr_en[n]        = alloc[n];
            map.wr_areg[n]      = lane.rd;
            map.wr_preg[n]      = fl_data_i[n];    // Show-ahead head
            fl_rd_o[n]          = alloc[n];

            ms_insn_valid_o[n] = in.fire & lane.valid;
            ms_insn_op_o[n]    = lane.op;
            ms_insn_rs1_o[n]   = map.src_preg[2*n];
            ms_insn_rs2_o[n]   = map.src_preg[2*n+1];
            ms_insn_dest_o[n]  = alloc[n] ? fl_data_i[n] : '0;

            rcu_insn_alloc_o[n]    = alloc[n];
            rcu_insn_arch_o[n]     = lane.rd;
            rcu_insn_old_preg_o[n] = map.dst_preg[n];
            rcu_insn_new_preg_o[n] = alloc[n] ? fl_data_i[n] : '0;
        end

        // Lane 1 displaces lane 0's new register, not the table entry
        if (alloc[0] && in.bundle[0].rd == in.bundle[1].rd) begin
            rcu_insn_old_preg_o[1] = fl_data_i[0];
        end
    end

endmodule

//--- logic/rn_skid_buffer.sv
`timescale 1ns/100ps

module rn_skid_buffer import rn_pkg::*; (
    input  logic        cpu_clock_i,
    input  logic        rst_i,
    input  logic        flush_i,
    input  logic        valid_i,
    input  rn_bundle_t  bundle_i,
    output logic        busy_o,
    rn_bundle_if.skid   out
);

    skid_state_e state_q;
    skid_state_e state_d;
    rn_bundle_t  head_q;
    rn_bundle_t  skid_q;
    logic        busy_q;
    logic        accept;
    logic        load_head;
    logic        load_skid;
    logic        pop_skid;

    assign accept = valid_i & ~busy_q;

    // **************************************************
    // Occupancy FSM
    // **************************************************
    always_comb begin
        state_d   = state_q;
        load_head = 1'b0;
        load_skid = 1'b0;
        pop_skid  = 1'b0;
        case (state_q)
            SKID_EMPTY: begin
                if (accept) begin
                    state_d   = SKID_ONE;
                    load_head = 1'b1;
                end
            end
            SKID_ONE: begin
                if (out.fire && accept) begin
                    load_head = 1'b1;   // Replace head, stay at one
                end else if (out.fire) begin
                    state_d = SKID_EMPTY;
                end else if (accept) begin
                    state_d   = SKID_TWO;
                    load_skid = 1'b1;
                end
            end
            SKID_TWO: begin
                if (out.fire) begin
                    state_d  = SKID_ONE;
                    pop_skid = 1'b1;    // Skid slot moves up
                end
            end
            default: state_d = SKID_EMPTY;
        endcase
        if (flush_i) begin
            state_d = SKID_EMPTY;   // Held bundles dropped
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (rst_i) begin
            state_q <= SKID_EMPTY;
            busy_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            busy_q  <= (state_d == SKID_TWO);
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (load_head) begin
            head_q <= bundle_i;
        end else if (pop_skid) begin
            head_q <= skid_q;
        end
        if (load_skid) begin
            skid_q <= bundle_i;
        end
    end

    assign out.valid  = (state_q != SKID_EMPTY);
    assign out.bundle = head_q;
    assign busy_o     = busy_q;

endmodule

//--- map_table/rn_map_table.sv
`timescale 1ns/100ps

module rn_map_table import rn_pkg::*; (
    input  logic                             cpu_clock_i,
    input  logic                             rst_i,
    input  logic                             flush_i,
    rn_map_if.tbl                            map,
    input  logic [NUM_LANES-1:0]             cm_we_i,
    input  logic [NUM_LANES-1:0][AREG_W-1:0] cm_arch_i,
    input  logic [NUM_LANES-1:0][PREG_W-1:0] cm_phys_i
);

    logic [PREG_W-1:0] spec_q [NUM_AREG];
    logic [PREG_W-1:0] comm_q [NUM_AREG];
    logic [PREG_W-1:0] comm_d [NUM_AREG];

    // Commits of this cycle, visible to a flush at the same edge
    always_comb begin
        comm_d = comm_q;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (cm_we_i[i] && cm_arch_i[i] != '0) begin
                comm_d[cm_arch_i[i]] = cm_phys_i[i];
            end
        end
    end

    // **************************************************
    // Map state
    // **************************************************
    always_ff @(posedge cpu_clock_i) begin
        if (rst_i) begin
            for (int r = 0; r < NUM_AREG; r++) begin
                spec_q[r] <= PREG_W'(r);    // Identity
                comm_q[r] <= PREG_W'(r);
            end
        end else begin
            comm_q <= comm_d;
            if (flush_i) begin
                spec_q <= comm_d;
            end else begin
                // Later lane overrides on equal index
                for (int i = 0; i < NUM_LANES; i++) begin
                    if (map.wr_en[i] && map.wr_areg[i] != '0) begin
                        spec_q[map.wr_areg[i]] <= map.wr_preg[i];
                    end
                end
            end
        end
    end

    // Reads see the table before this bundle's writes
    always_comb begin
        for (int s = 0; s < NUM_SRC; s++) begin
            map.src_preg[s] = spec_q[map.src_areg[s]];
        end
        for (int d = 0; d < NUM_LANES; d++) begin
            map.dst_preg[d] = spec_q[map.dst_areg[d]];
        end
    end

endmodule

//--- sim.f
common/rn_pkg.sv
common/rn_if.sv
logic/rn_skid_buffer.sv
map_table/rn_map_table.sv
logic/rn_dispatch.sv
logic/rename.sv
verification/rename_assertions.sv
verification/rename_tb.sv

//--- verification/rename_assertions.sv
`timescale 1ns/100ps

module rename_assertions (
    input logic cpu_clock_i,
    input logic rst_i,
    input logic flush_i,
    input logic rcu_push_o,
    input logic fl_rd0_o,
    input logic fl_rd1_o,
    input logic fl_empty0_i,
    input logic fl_empty1_i,
    input logic rn_busy_o
);

    // Free-list pops only with a pushed bundle
    pop_needs_push: assert property (@(posedge cpu_clock_i) disable iff (rst_i)
        (fl_rd0_o || fl_rd1_o) |-> rcu_push_o)
        else $error("free-list pop without rcu_push_o");

    pop0_not_empty: assert property (@(posedge cpu_clock_i) disable iff (rst_i)
        !(fl_rd0_o && fl_empty0_i))
        else $error("lane 0 pop while its free list is empty");

    pop1_not_empty: assert property (@(posedge cpu_clock_i) disable iff (rst_i)
        !(fl_rd1_o && fl_empty1_i))
        else $error("lane 1 pop while its free list is empty");

    // Full buffer frees a slot once the head leaves
    busy_falls_on_fire: assert property (@(posedge cpu_clock_i) disable iff (rst_i)
        (rn_busy_o && rcu_push_o && !flush_i) |=> !rn_busy_o)
        else $error("rn_busy_o held after the head fired");

endmodule

bind rename rename_assertions u_assertions (.*);

//--- verification/rename_tb.sv
`timescale 1ns/100ps

module rename_tb import rn_pkg::*; ();

    typedef struct packed {
        logic                             v1;
        logic [1:0][3:0]                  op;
        logic [1:0][AREG_W-1:0]           rd;
        logic [1:0][PREG_W-1:0]           rs1;
        logic [1:0][PREG_W-1:0]           rs2;
        logic [1:0][PREG_W-1:0]           dest;
        logic [1:0][PREG_W-1:0]           old;
    } exp_pkt_t;

    localparam int WAIT_LIMIT = 200;

    logic cpu_clock_i, rst_i, flush_i, valid_i, rn_busy_o;
    alu_op_e lane0_op_i, lane1_op_i;
    logic [AREG_W-1:0] lane0_rs1_i, lane0_rs2_i, lane0_rd_i;
    logic [AREG_W-1:0] lane1_rs1_i, lane1_rs2_i, lane1_rd_i;
    logic lane0_writes_rd_i, lane1_writes_rd_i, lane1_valid_i;
    logic fl_rd0_o, fl_rd1_o, fl_empty0_i, fl_empty1_i;
    logic [PREG_W-1:0] fl_data0_i, fl_data1_i;
    logic ms_ins0_valid_o, ms_ins1_valid_o, ms_busy_i;
    alu_op_e ms_ins0_op_o, ms_ins1_op_o;
    logic [PREG_W-1:0] ms_ins0_rs1_o, ms_ins0_rs2_o, ms_ins0_dest_o;
    logic [PREG_W-1:0] ms_ins1_rs1_o, ms_ins1_rs2_o, ms_ins1_dest_o;
    logic rcu_push_o, rcu_ins1_valid_o, rcu_busy_i;
    logic rcu_ins0_alloc_o, rcu_ins1_alloc_o;
    logic [AREG_W-1:0] rcu_ins0_arch_o, rcu_ins1_arch_o;
    logic [PREG_W-1:0] rcu_ins0_old_preg_o, rcu_ins0_new_preg_o;
    logic [PREG_W-1:0] rcu_ins1_old_preg_o, rcu_ins1_new_preg_o;
    logic cm0_we_i, cm1_we_i;
    logic [AREG_W-1:0] cm0_arch_i, cm1_arch_i;
    logic [PREG_W-1:0] cm0_phys_i, cm1_phys_i;

    logic [PREG_W-1:0] next_preg;
    exp_pkt_t          exp_q [$];
    exp_pkt_t          cur;
    int                errors = 0;
    int                checked = 0;
    int                stall_left = 0;
    int                in_flight = 0;
    int                f [23];

    rename dut (.*);

    initial begin
        cpu_clock_i = 1'b0;
        forever #2 cpu_clock_i = ~cpu_clock_i;
    end

    // **************************************************
    // Free-list model
    // **************************************************
    assign fl_data0_i = next_preg;
    assign fl_data1_i = fl_rd0_o ? next_preg + PREG_W'(1) : next_preg;

    always @(posedge cpu_clock_i) begin : free_list_advance
        logic [PREG_W-1:0] pops;
        pops = '0;
        if (!rst_i) begin
            pops = PREG_W'(fl_rd0_o) + PREG_W'(fl_rd1_o);
        end
        #1;
        next_preg = next_preg + pops;
    end

    task automatic check_value(input string name, input int got, input int expv);
        if (got != expv) begin
            $display("ERR %0t %s expected %0d got %0d", $time, name, expv, got);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("Packets checked %0d, errors %0d", checked, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic abort_timeout(input string what);
        errors++;
        $display("Timeout while waiting for %s", what);
        $display("Packets checked %0d, errors %0d", checked, errors);
        $display("Verification failed");
        $finish;
    endtask

    // Inputs change 1 ns after the edge
    task automatic step();
        @(posedge cpu_clock_i);
        #1;
        if (stall_left > 0) begin
            stall_left--;
            if (stall_left == 0) begin
                ms_busy_i   = 1'b0;
                rcu_busy_i  = 1'b0;
                fl_empty0_i = 1'b0;
                fl_empty1_i = 1'b0;
            end
        end
    endtask

    task automatic wait_not_busy();
        int cycles;
        cycles = 0;
        while (rn_busy_o) begin
            step();
            cycles++;
            if (cycles >= WAIT_LIMIT) abort_timeout("rn_busy_o to fall");
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 || stall_left != 0) begin
            step();
            cycles++;
            if (cycles >= WAIT_LIMIT) abort_timeout("expected packets to drain");
        end
    endtask

    task automatic send_bundle();
        exp_pkt_t e;
        wait_not_busy();
        lane0_op_i        = alu_op_e'(f[2]);
        lane0_rs1_i       = AREG_W'(f[3]);
        lane0_rs2_i       = AREG_W'(f[4]);
        lane0_rd_i        = AREG_W'(f[5]);
        lane0_writes_rd_i = f[6][0];
        lane1_valid_i     = f[1][0];
        lane1_op_i        = alu_op_e'(f[7]);
        lane1_rs1_i       = AREG_W'(f[8]);
        lane1_rs2_i       = AREG_W'(f[9]);
        lane1_rd_i        = AREG_W'(f[10]);
        lane1_writes_rd_i = f[11][0];
        if (f[13] > 0) begin
            ms_busy_i   = f[12][0];
            rcu_busy_i  = f[12][1];
            fl_empty0_i = f[12][2];
            fl_empty1_i = f[12][2];
            stall_left  = f[13];
        end
        if (f[14] != 0) begin
            e.v1     = f[1][0];
            e.op[0]  = 4'(f[2]);
            e.op[1]  = 4'(f[7]);
            e.rd[0]  = AREG_W'(f[5]);
            e.rd[1]  = AREG_W'(f[10]);
            for (int n = 0; n < 2; n++) begin
                e.rs1[n]  = PREG_W'(f[15+4*n]);
                e.rs2[n]  = PREG_W'(f[16+4*n]);
                e.dest[n] = PREG_W'(f[17+4*n]);
                e.old[n]  = PREG_W'(f[18+4*n]);
            end
            exp_q.push_back(e);
        end
        valid_i = 1'b1;
        step();
        valid_i = 1'b0;
        in_flight++;   // Accepted at that edge
    endtask

    task automatic send_command();
        cm0_we_i   = f[1][0];
        cm0_arch_i = AREG_W'(f[2]);
        cm0_phys_i = PREG_W'(f[3]);
        cm1_we_i   = f[4][0];
        cm1_arch_i = AREG_W'(f[5]);
        cm1_phys_i = PREG_W'(f[6]);
        flush_i    = f[7][0];
        step();
        if (flush_i) begin
            in_flight = 0;   // Held bundles dropped
        end
        cm0_we_i = 1'b0;
        cm1_we_i = 1'b0;
        flush_i  = 1'b0;
    endtask

    // **************************************************
    // Packet monitor sampled mid-cycle
    // **************************************************
    always @(negedge cpu_clock_i) begin
        if (!rst_i) begin
            check_value("rn_busy_o", int'(rn_busy_o), int'(in_flight == 2));  // Both entries full
        end
        if (!rst_i && rcu_push_o) begin
            in_flight--;
            if (ms_busy_i || rcu_busy_i || fl_empty0_i || fl_empty1_i) begin
                $display("Bundle pushed at %0t while a stall input was high", $time);
                errors++;
            end
            if (exp_q.size() == 0) begin
                $display("Unexpected bundle pushed at %0t", $time);
                errors++;
            end else begin
                cur = exp_q.pop_front();
                checked++;
                check_value("ms_ins0_valid_o", int'(ms_ins0_valid_o), 1);
                check_value("ms_ins0_op_o", int'(ms_ins0_op_o), int'(cur.op[0]));
                check_value("ms_ins0_rs1_o", int'(ms_ins0_rs1_o), int'(cur.rs1[0]));
                check_value("ms_ins0_rs2_o", int'(ms_ins0_rs2_o), int'(cur.rs2[0]));
                check_value("ms_ins0_dest_o", int'(ms_ins0_dest_o), int'(cur.dest[0]));
                check_value("rcu_ins0_alloc_o", int'(rcu_ins0_alloc_o), int'(cur.dest[0] != 0));
                check_value("rcu_ins0_arch_o", int'(rcu_ins0_arch_o), int'(cur.rd[0]));
                check_value("rcu_ins0_old_preg_o", int'(rcu_ins0_old_preg_o), int'(cur.old[0]));
                check_value("rcu_ins0_new_preg_o", int'(rcu_ins0_new_preg_o), int'(cur.dest[0]));
                check_value("fl_rd0_o", int'(fl_rd0_o), int'(cur.dest[0] != 0));
                check_value("fl_rd1_o", int'(fl_rd1_o), int'(cur.v1 && cur.dest[1] != 0));
                check_value("rcu_ins1_alloc_o", int'(rcu_ins1_alloc_o),
                            int'(cur.v1 && cur.dest[1] != 0));
                check_value("ms_ins1_valid_o", int'(ms_ins1_valid_o), int'(cur.v1));
                check_value("rcu_ins1_valid_o", int'(rcu_ins1_valid_o), int'(cur.v1));
                if (cur.v1) begin
                    check_value("ms_ins1_op_o", int'(ms_ins1_op_o), int'(cur.op[1]));
                    check_value("ms_ins1_rs1_o", int'(ms_ins1_rs1_o), int'(cur.rs1[1]));
                    check_value("ms_ins1_rs2_o", int'(ms_ins1_rs2_o), int'(cur.rs2[1]));
                    check_value("ms_ins1_dest_o", int'(ms_ins1_dest_o), int'(cur.dest[1]));
                    check_value("rcu_ins1_arch_o", int'(rcu_ins1_arch_o), int'(cur.rd[1]));
                    check_value("rcu_ins1_old_preg_o", int'(rcu_ins1_old_preg_o),
                                int'(cur.old[1]));
                    check_value("rcu_ins1_new_preg_o", int'(rcu_ins1_new_preg_o),
                                int'(cur.dest[1]));
                end
            end
        end
    end

    initial begin
        int                fd;
        int                kind;
        int                code;
        logic [8*256-1:0] line;
        rst_i = 1'b1;
        flush_i = 1'b0;
        valid_i = 1'b0;
        lane0_op_i = ADD;
        lane1_op_i = ADD;
        {lane0_rs1_i, lane0_rs2_i, lane0_rd_i} = '0;
        {lane1_rs1_i, lane1_rs2_i, lane1_rd_i} = '0;
        lane0_writes_rd_i = 1'b0;
        lane1_writes_rd_i = 1'b0;
        lane1_valid_i = 1'b0;
        {fl_empty0_i, fl_empty1_i, ms_busy_i, rcu_busy_i} = '0;
        {cm0_we_i, cm1_we_i} = '0;
        {cm0_arch_i, cm1_arch_i} = '0;
        {cm0_phys_i, cm1_phys_i} = '0;
        next_preg = PREG_W'(32);   // First free register after identity
        repeat (2) @(posedge cpu_clock_i);
        #1;
        rst_i = 1'b0;

        fd = $fopen("verification/rename_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the trace file");
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                code = $fgets(line, fd);
                kind = -1;
                code = $sscanf(line, "%d", kind);   // Comment and blank lines skip
                if (code == 1) begin
                    code = $sscanf(line,
                        "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                        f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                        f[20], f[21], f[22]);
                    case (kind)
                        0: send_bundle();
                        1: send_command();
                        default: wait_drain();
                    endcase
                end
            end
            $fclose(fd);
        end
        wait_drain();
        repeat (20) step();   // Dropped bundles must stay gone
        finish_run();
    end

endmodule

//--- verification/rename_trace.txt
# 0 bundle: v1 op0 rs1 rs2 rd wr op1 rs1 rs2 rd wr mask cycles expect, then per lane rs1 rs2 dest old
# 1 command: we0 arch0 phys0 we1 arch1 phys1 flush; 2 drain. mask bits: 0 ms, 1 rcu, 2 fl empty
0 1 0 1 2 3 1 1 3 4 5 1 0 0 1 1 2 32 3 3 4 33 5
0 1 2 3 5 0 1 3 6 7 8 0 0 0 1 32 33 0 0 6 7 0 8
0 1 4 9 10 9 1 5 9 3 9 1 0 0 1 9 10 34 9 9 32 35 34
0 0 6 9 0 10 1 0 0 0 0 0 0 0 1 35 0 36 10 0 0 0 0
0 1 7 10 5 11 1 8 11 12 12 1 1 6 1 36 33 37 11 11 12 38 12
0 1 9 11 12 13 1 10 0 0 14 1 0 0 1 37 38 39 13 0 0 40 14
0 0 0 13 14 15 1 0 0 0 0 0 0 0 1 39 40 41 15 0 0 0 0
0 1 0 15 3 16 1 1 16 9 17 1 4 3 1 41 32 42 16 16 35 43 17
0 0 3 16 17 3 1 0 0 0 0 0 2 2 1 42 43 44 32 0 0 0 0
2
0 0 0 1 1 20 1 0 0 0 0 0 1 10 0 0 0 0 0 0 0 0 0
0 0 0 2 2 21 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 3 32 1 9 34 1
0 1 0 3 9 5 1 1 10 16 3 1 0 0 1 32 34 45 5 10 16 46 32
0 0 2 5 3 0 0 0 0 0 0 0 0 0 1 45 46 0 0 0 0 0 0
